// File: Bender.yml
package:
  name: rf_ecc_top

sources:
  # RTL in compile order
  - files:
      - verilog/rf_ecc_pkg.sv
      - verilog/rf_ecc_encoder.sv
      - verilog/rf_ecc_storage.sv
      - verilog/rf_ecc_read_checker.sv
      - verilog/rf_alert.sv
      - verilog/rf_ecc_top.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - dv/rf_ecc_assertions.sv
      - dv/rf_ecc_tb.sv

// File: dv/rf_ecc_assertions.sv
`timescale 1ns/1ps

module rf_ecc_assertions #(
  parameter int NUM_REGS = 32
) (
  input logic                  clk,
  input logic                  rst_n_i,
  input logic                  we_i,
  input rf_ecc_pkg::rf_addr_t  waddr_i,
  input rf_ecc_pkg::rf_data_t  wdata_i,
  input logic                  re_a_i,
  input rf_ecc_pkg::rf_addr_t  raddr_a_i,
  input rf_ecc_pkg::rf_data_t  rdata_a_o,
  input logic                  re_b_i,
  input rf_ecc_pkg::rf_addr_t  raddr_b_i,
  input rf_ecc_pkg::rf_data_t  rdata_b_o,
  input logic                  alert_major_o
);

  // Whole address space, unused entries stay zero
  localparam int DEPTH = 2 ** rf_ecc_pkg::ADDR_WIDTH;

  // Last data written per register
  rf_ecc_pkg::rf_data_t shadow [DEPTH];
  // Set by the testbench on fault injection
  logic                 corrupt [DEPTH];
  // Failures seen so far, read by the testbench
  int                   err_count = 0;

  logic wr_hit;
  logic exp_err;

  // x0 and out of range writes are dropped
  assign wr_hit  = we_i && (waddr_i != '0) && (int'(waddr_i) < NUM_REGS);
  // Enabled read of a damaged word
  assign exp_err = (re_a_i && corrupt[raddr_a_i]) || (re_b_i && corrupt[raddr_b_i]);

  //////////////////////////////////////////////////////////////////////
  // Shadow model
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n_i) begin
      for (int r = 0; r < DEPTH; r++) begin
        shadow[r]  <= '0;
        corrupt[r] <= 1'b0;
      end
    end else if (wr_hit) begin
      // A fresh write also repairs the word
      shadow[waddr_i]  <= wdata_i;
      corrupt[waddr_i] <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Properties
  //////////////////////////////////////////////////////////////////////

  reset_clears_alert: assert property (@(posedge clk) !rst_n_i |=> !alert_major_o)
    else begin
      err_count++;
      $error("mismatch at %0t: alert_major_o got %b exp 0", $time, $sampled(alert_major_o));
    end

  alert_after_error: assert property (@(posedge clk) disable iff (!rst_n_i)
    exp_err |=> alert_major_o)
    else begin
      err_count++;
      $error("mismatch at %0t: alert_major_o got %b exp 1", $time, $sampled(alert_major_o));
    end

  no_alert_when_clean: assert property (@(posedge clk) disable iff (!rst_n_i)
    !exp_err |=> !alert_major_o)
    else begin
      err_count++;
      $error("mismatch at %0t: alert_major_o got %b exp 0", $time, $sampled(alert_major_o));
    end

  // Clean words read back the shadow value, old value on a same cycle write
  rdata_a_matches: assert property (@(posedge clk) disable iff (!rst_n_i)
    re_a_i && !corrupt[raddr_a_i] |-> rdata_a_o == shadow[raddr_a_i])
    else begin
      err_count++;
      $error("mismatch at %0t: rdata_a_o got %h exp %h", $time,
             $sampled(rdata_a_o), $sampled(shadow[raddr_a_i]));
    end

  rdata_b_matches: assert property (@(posedge clk) disable iff (!rst_n_i)
    re_b_i && !corrupt[raddr_b_i] |-> rdata_b_o == shadow[raddr_b_i])
    else begin
      err_count++;
      $error("mismatch at %0t: rdata_b_o got %h exp %h", $time,
             $sampled(rdata_b_o), $sampled(shadow[raddr_b_i]));
    end

endmodule

bind rf_ecc_top rf_ecc_assertions #(
  .NUM_REGS ( NUM_REGS )
) asrt0 (
  .clk           ( clk           ),
  .rst_n_i       ( rst_n_i       ),
  .we_i          ( we_i          ),
  .waddr_i       ( waddr_i       ),
  .wdata_i       ( wdata_i       ),
  .re_a_i        ( re_a_i        ),
  .raddr_a_i     ( raddr_a_i     ),
  .rdata_a_o     ( rdata_a_o     ),
  .re_b_i        ( re_b_i        ),
  .raddr_b_i     ( raddr_b_i     ),
  .rdata_b_o     ( rdata_b_o     ),
  .alert_major_o ( alert_major_o )
);

// File: dv/rf_ecc_tb.sv
`timescale 1ns/1ps

module rf_ecc_tb;

  localparam int CLK_PERIOD      = 8;
  localparam int NUM_TESTS       = 6;
  // Generous bound on any single test
  localparam int CYCLES_PER_TEST = 300;

  logic                  clk;
  logic                  rst_n_i;
  logic                  we_i;
  rf_ecc_pkg::rf_addr_t  waddr_i;
  rf_ecc_pkg::rf_data_t  wdata_i;
  logic                  re_a_i;
  rf_ecc_pkg::rf_addr_t  raddr_a_i;
  rf_ecc_pkg::rf_data_t  rdata_a_o;
  logic                  re_b_i;
  rf_ecc_pkg::rf_addr_t  raddr_b_i;
  rf_ecc_pkg::rf_data_t  rdata_b_o;
  logic                  alert_major_o;

  logic [31:0] lcg_state = 32'd64732;
  int          tests_run    = 0;
  int          tests_failed = 0;
  int          errs_before  = 0;

  rf_ecc_top #(
    .NUM_REGS ( 32 )
  ) dut0 (
    .clk           ( clk           ),
    .rst_n_i       ( rst_n_i       ),
    .we_i          ( we_i          ),
    .waddr_i       ( waddr_i       ),
    .wdata_i       ( wdata_i       ),
    .re_a_i        ( re_a_i        ),
    .raddr_a_i     ( raddr_a_i     ),
    .rdata_a_o     ( rdata_a_o     ),
    .re_b_i        ( re_b_i        ),
    .raddr_b_i     ( raddr_b_i     ),
    .rdata_b_o     ( rdata_b_o     ),
    .alert_major_o ( alert_major_o )
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper bits, the low LCG bits cycle fast
  function automatic int rand_below(input int n);
    return int'((next_random() >> 16) % n);
  endfunction

  function automatic rf_ecc_pkg::rf_addr_t rand_reg();
    return rf_ecc_pkg::rf_addr_t'(1 + rand_below(31));
  endfunction

  // One or two distinct bits out of the 39
  // First bit either in the check bits or in the data bits
  function automatic rf_ecc_pkg::rf_cword_t fault_mask(input int nbits, input logic in_ecc);
    rf_ecc_pkg::rf_cword_t m;
    int                    b0;
    int                    b1;
    if (in_ecc) begin
      b0 = rf_ecc_pkg::DATA_WIDTH + rand_below(rf_ecc_pkg::ECC_WIDTH);
    end else begin
      b0 = rand_below(rf_ecc_pkg::DATA_WIDTH);
    end
    m  = rf_ecc_pkg::rf_cword_t'(1) << b0;
    if (nbits == 2) begin
      b1 = (b0 + 1 + rand_below(38)) % 39;
      m  = m | (rf_ecc_pkg::rf_cword_t'(1) << b1);
    end
    return m;
  endfunction

  task automatic drive_cycle(input logic we, input rf_ecc_pkg::rf_addr_t waddr,
                             input rf_ecc_pkg::rf_data_t wdata,
                             input logic re_a, input rf_ecc_pkg::rf_addr_t raddr_a,
                             input logic re_b, input rf_ecc_pkg::rf_addr_t raddr_b);
    @(posedge clk);
    we_i      <= we;
    waddr_i   <= waddr;
    wdata_i   <= wdata;
    re_a_i    <= re_a;
    raddr_a_i <= raddr_a;
    re_b_i    <= re_b;
    raddr_b_i <= raddr_b;
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, '0, '0, 1'b0, '0, 1'b0, '0);
  endtask

  // Mid cycle, clear of the write edge
  task automatic flip_bits(input rf_ecc_pkg::rf_addr_t addr,
                           input rf_ecc_pkg::rf_cword_t mask);
    @(negedge clk);
    dut0.storage0.mem[addr] = dut0.storage0.mem[addr] ^ mask;
    dut0.asrt0.corrupt[addr] = 1'b1;
  endtask

  // Drain pending |=> checks, then score the test
  task automatic finish_test(input string name);
    int errs;
    repeat (3) idle_cycle();
    errs = dut0.asrt0.err_count - errs_before;
    errs_before = dut0.asrt0.err_count;
    tests_run++;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errs);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    for (int r = 0; r < 32; r++) begin
      drive_cycle(1'b0, '0, '0, 1'b1, r, 1'b1, 31 - r);
    end
    finish_test("reset_state");
  endtask

  task automatic test_random_rw();
    rf_ecc_pkg::rf_addr_t a;
    for (int i = 0; i < 48; i++) begin
      a = rf_ecc_pkg::rf_addr_t'(rand_below(32));
      // Every other cycle port A reads the address under write
      drive_cycle(1'b1, a, next_random(), 1'b1, (i % 2) ? a : rand_reg(),
                  1'b1, rf_ecc_pkg::rf_addr_t'(rand_below(32)));
    end
    for (int r = 0; r < 32; r++) begin
      drive_cycle(1'b0, '0, '0, 1'b1, r, 1'b1, r);
    end
    finish_test("random_rw");
  endtask

  task automatic test_zero_reg();
    repeat (8) drive_cycle(1'b1, '0, next_random(), 1'b1, '0, 1'b1, '0);
    idle_cycle();
    drive_cycle(1'b0, '0, '0, 1'b1, '0, 1'b1, '0);
    finish_test("zero_reg");
  endtask

  // Alternates the faulty read between ports, other port reads a clean word
  task automatic test_flip(input string name, input int nbits);
    rf_ecc_pkg::rf_addr_t addr;
    rf_ecc_pkg::rf_addr_t other;
    for (int i = 0; i < 8; i++) begin
      addr  = rand_reg();
      other = (addr == 31) ? 5'd1 : addr + 5'd1;
      drive_cycle(1'b1, addr, next_random(), 1'b0, '0, 1'b0, '0);
      idle_cycle();
      // First round on each port hits a check bit
      flip_bits(addr, fault_mask(nbits, i < 2));
      if (i % 2 == 0) begin
        drive_cycle(1'b0, '0, '0, 1'b1, addr, 1'b1, other);
      end else begin
        drive_cycle(1'b0, '0, '0, 1'b1, other, 1'b1, addr);
      end
      idle_cycle();
      // Repair before the next round
      drive_cycle(1'b1, addr, next_random(), 1'b0, '0, 1'b0, '0);
      idle_cycle();
    end
    finish_test(name);
  endtask

  task automatic test_masked_read();
    rf_ecc_pkg::rf_addr_t addr;
    for (int i = 0; i < 4; i++) begin
      addr = rand_reg();
      drive_cycle(1'b1, addr, next_random(), 1'b0, '0, 1'b0, '0);
      idle_cycle();
      flip_bits(addr, fault_mask(1, 1'b0));
      // Damaged word on both ports, enables low
      repeat (2) drive_cycle(1'b0, '0, '0, 1'b0, addr, 1'b0, addr);
      drive_cycle(1'b1, addr, next_random(), 1'b0, addr, 1'b0, addr);
      drive_cycle(1'b0, '0, '0, 1'b1, addr, 1'b1, addr);
    end
    finish_test("masked_read");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main flow and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk       = 1'b0;
    rst_n_i   = 1'b0;
    we_i      = 1'b0;
    waddr_i   = '0;
    wdata_i   = '0;
    re_a_i    = 1'b0;
    raddr_a_i = '0;
    re_b_i    = 1'b0;
    raddr_b_i = '0;
    repeat (2) @(posedge clk);
    rst_n_i <= 1'b1;
    test_reset_state();
    test_random_rw();
    test_zero_reg();
    test_flip("single_flip", 1);
    test_flip("double_flip", 2);
    test_masked_read();
    $display("%0d tests, %0d passed, %0d failed, %0d assertion errors",
             tests_run, tests_run - tests_failed, tests_failed, dut0.asrt0.err_count);
    if (tests_failed == 0 && dut0.asrt0.err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD + 1000);
    $display("timeout: tests did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: rf_ecc_top.f
verilog/rf_ecc_pkg.sv
verilog/rf_ecc_encoder.sv
verilog/rf_ecc_storage.sv
verilog/rf_ecc_read_checker.sv
verilog/rf_alert.sv
verilog/rf_ecc_top.sv
dv/rf_ecc_assertions.sv
dv/rf_ecc_tb.sv

// File: verilog/rf_alert.sv
`timescale 1ns/1ps

module rf_alert (
  input  logic clk,
  input  logic rst_n_i,

  // Read errors, already gated by read enable
  input  logic err_a_i,
  input  logic err_b_i,

  // Major security alert
  output logic alert_major_o
);

  // Error on either port this cycle
  logic err_any;

  //////////////////////////////////////////////////////////////////////
  // Combine
  //////////////////////////////////////////////////////////////////////

  assign err_any = err_a_i | err_b_i;

  //////////////////////////////////////////////////////////////////////
  // Alert flop
  //////////////////////////////////////////////////////////////////////

  // One cycle after the bad read
  // Registered so the alert never glitches
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      alert_major_o <= 1'b0;
    end else begin
      // High for exactly one cycle per bad read cycle
      alert_major_o <= err_any;
    end
  end

endmodule

// File: verilog/rf_ecc_encoder.sv
`timescale 1ns/1ps

module rf_ecc_encoder (
  // Raw data word
  input  rf_ecc_pkg::rf_data_t data_i,
  // Check bits for it
  output rf_ecc_pkg::rf_ecc_t  ecc_o
);

  // Hamming part, one bit per position bit
  logic [rf_ecc_pkg::ECC_WIDTH-2:0] hamming;
  // Parity over data only
  logic                             data_parity;
  // Parity over the Hamming bits
  logic                             hamming_parity;

  //////////////////////////////////////////////////////////////////////
  // Hamming check bits
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < rf_ecc_pkg::ECC_WIDTH - 1; i++) begin
      // XOR of the masked data bits
      hamming[i] = ^(data_i & rf_ecc_pkg::ECC_MASKS[i]);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Overall parity
  //////////////////////////////////////////////////////////////////////

  // Mask 6 covers every data bit
  assign data_parity    = ^(data_i & rf_ecc_pkg::ECC_MASKS[rf_ecc_pkg::ECC_WIDTH-1]);
  assign hamming_parity = ^hamming;

  // Even parity over the whole code word
  // Zero data gives zero check bits
  assign ecc_o = {data_parity ^ hamming_parity, hamming};

endmodule

// File: verilog/rf_ecc_pkg.sv
package rf_ecc_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Data bits per register
  localparam int DATA_WIDTH = 32;
  // Six Hamming bits plus one overall parity bit
  localparam int ECC_WIDTH  = 7;
  // Enough for x0..x31
  localparam int ADDR_WIDTH = 5;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [ADDR_WIDTH-1:0] rf_addr_t;
  typedef logic [DATA_WIDTH-1:0] rf_data_t;
  typedef logic [ECC_WIDTH-1:0]  rf_ecc_t;

  // Stored word, data in [31:0], check bits in [38:32]
  typedef logic [DATA_WIDTH+ECC_WIDTH-1:0] rf_cword_t;

  //////////////////////////////////////////////////////////////////////
  // Parity masks
  //////////////////////////////////////////////////////////////////////

  // Data bit d sits at the d-th non power of two Hamming position
  // Mask i picks data bits whose position has bit i set
  // Mask 6 is the overall parity, the encoder adds check bits 0..5
  localparam logic [ECC_WIDTH-1:0][DATA_WIDTH-1:0] ECC_MASKS = {
    32'hFFFF_FFFF,  // 6
    32'hFC00_0000,  // 5
    32'h03FF_F800,  // 4
    32'h03FC_07F0,  // 3
    32'hE3C3_C78E,  // 2
    32'h9B33_366D,  // 1
    32'h56AA_AD5B   // 0
  };

endpackage

// File: verilog/rf_ecc_read_checker.sv
`timescale 1ns/1ps

module rf_ecc_read_checker (
  // Code word from the array
  input  rf_ecc_pkg::rf_cword_t cword_i,

  // Data, not corrected
  output rf_ecc_pkg::rf_data_t  rdata_o,

  // Any syndrome bit set
  output logic                  err_o
);

  // Fields of the code word
  rf_ecc_pkg::rf_data_t stored_data;
  rf_ecc_pkg::rf_ecc_t  stored_ecc;

  // Check bits recomputed from the data
  rf_ecc_pkg::rf_ecc_t  calc_ecc;

  // Difference between the two
  rf_ecc_pkg::rf_ecc_t  syndrome;

  //////////////////////////////////////////////////////////////////////
  // Split
  //////////////////////////////////////////////////////////////////////

  // Data low, check bits above
  assign stored_data = cword_i[rf_ecc_pkg::DATA_WIDTH-1:0];
  assign stored_ecc  = cword_i[rf_ecc_pkg::DATA_WIDTH +: rf_ecc_pkg::ECC_WIDTH];

  //////////////////////////////////////////////////////////////////////
  // Recompute and compare
  //////////////////////////////////////////////////////////////////////

  rf_ecc_encoder enc0 (
    .data_i ( stored_data ),
    .ecc_o  ( calc_ecc    )
  );

  assign syndrome = calc_ecc ^ stored_ecc;

  // Distance 4 code
  // One, two or three flipped bits never give a zero syndrome
  assign err_o = |syndrome;

  // Pass through, detection only
  assign rdata_o = stored_data;

endmodule

// File: verilog/rf_ecc_storage.sv
`timescale 1ns/1ps

module rf_ecc_storage #(
  // 32 for RV32I, 16 for RV32E
  parameter int NUM_REGS = 32
) (
  input  logic                   clk,
  input  logic                   rst_n_i,

  // Write port
  input  logic                   we_i,
  input  rf_ecc_pkg::rf_addr_t   waddr_i,
  input  rf_ecc_pkg::rf_cword_t  wcword_i,

  // Read port A
  input  rf_ecc_pkg::rf_addr_t   raddr_a_i,
  output rf_ecc_pkg::rf_cword_t  rcword_a_o,

  // Read port B
  input  rf_ecc_pkg::rf_addr_t   raddr_b_i,
  output rf_ecc_pkg::rf_cword_t  rcword_b_o
);

  // x1 and up, x0 has no storage
  rf_ecc_pkg::rf_cword_t mem [1:NUM_REGS-1];

  // Address decode
  logic wr_valid;
  logic rd_valid_a;
  logic rd_valid_b;

  //////////////////////////////////////////////////////////////////////
  // Address checks
  //////////////////////////////////////////////////////////////////////

  // Drop x0 and anything past the last register
  assign wr_valid   = we_i && (waddr_i != '0) && (int'(waddr_i) < NUM_REGS);

  // Same test on the read side
  assign rd_valid_a = (raddr_a_i != '0) && (int'(raddr_a_i) < NUM_REGS);
  assign rd_valid_b = (raddr_b_i != '0) && (int'(raddr_b_i) < NUM_REGS);

  //////////////////////////////////////////////////////////////////////
  // Register array
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      // All zero is a valid code word
      for (int r = 1; r < NUM_REGS; r++) begin
        mem[r] <= '0;
      end
    end else if (wr_valid) begin
      // Lands at the next edge
      mem[waddr_i] <= wcword_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////////////////////////

  // Straight from the array, no write bypass
  // x0 reads as the zero code word
  assign rcword_a_o = rd_valid_a ? mem[raddr_a_i] : '0;
  assign rcword_b_o = rd_valid_b ? mem[raddr_b_i] : '0;

endmodule

// File: verilog/rf_ecc_top.sv
`timescale 1ns/1ps

module rf_ecc_top #(
  // Register count, 16 gives RV32E
  parameter int NUM_REGS = 32
) (
  input  logic                 clk,
  input  logic                 rst_n_i,

  // Write port
  input  logic                 we_i,
  input  rf_ecc_pkg::rf_addr_t waddr_i,
  input  rf_ecc_pkg::rf_data_t wdata_i,

  // Read port A
  input  logic                 re_a_i,
  input  rf_ecc_pkg::rf_addr_t raddr_a_i,
  output rf_ecc_pkg::rf_data_t rdata_a_o,

  // Read port B
  input  logic                 re_b_i,
  input  rf_ecc_pkg::rf_addr_t raddr_b_i,
  output rf_ecc_pkg::rf_data_t rdata_b_o,

  // Security alert
  output logic                 alert_major_o
);

  // Write path
  rf_ecc_pkg::rf_ecc_t   wecc;
  rf_ecc_pkg::rf_cword_t wcword;

  // Read path
  rf_ecc_pkg::rf_cword_t rcword_a;
  rf_ecc_pkg::rf_cword_t rcword_b;

  // Raw checker flags
  logic                  ecc_err_a;
  logic                  ecc_err_b;

  // Only reads that are used count
  logic                  err_a_gated;
  logic                  err_b_gated;

  //////////////////////////////////////////////////////////////////////
  // Write encode
  //////////////////////////////////////////////////////////////////////

  rf_ecc_encoder enc0 (
    .data_i ( wdata_i ),
    .ecc_o  ( wecc    )
  );

  // Check bits on top of data
  assign wcword = {wecc, wdata_i};

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  rf_ecc_storage #(
    .NUM_REGS ( NUM_REGS )
  ) storage0 (
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .we_i       ( we_i      ),
    .waddr_i    ( waddr_i   ),
    .wcword_i   ( wcword    ),
    .raddr_a_i  ( raddr_a_i ),
    .rcword_a_o ( rcword_a  ),
    .raddr_b_i  ( raddr_b_i ),
    .rcword_b_o ( rcword_b  )
  );

  //////////////////////////////////////////////////////////////////////
  // Read checks
  //////////////////////////////////////////////////////////////////////

  // Both ports checked side by side
  rf_ecc_read_checker chk_a (
    .cword_i ( rcword_a  ),
    .rdata_o ( rdata_a_o ),
    .err_o   ( ecc_err_a )
  );

  rf_ecc_read_checker chk_b (
    .cword_i ( rcword_b  ),
    .rdata_o ( rdata_b_o ),
    .err_o   ( ecc_err_b )
  );

  // Idle port reads are ignored
  assign err_a_gated = ecc_err_a & re_a_i;
  assign err_b_gated = ecc_err_b & re_b_i;

  //////////////////////////////////////////////////////////////////////
  // Alert
  //////////////////////////////////////////////////////////////////////

  rf_alert alert0 (
    .clk           ( clk           ),
    .rst_n_i       ( rst_n_i       ),
    .err_a_i       ( err_a_gated   ),
    .err_b_i       ( err_b_gated   ),
    .alert_major_o ( alert_major_o )
  );

endmodule
